// File: tlb_top.f
+incdir+testbench
hdl/tlb_pkg.sv
hdl/tlb_way_ram.sv
hdl/tlb_delay_line.sv
hdl/tlb_tag_compare.sv
hdl/tlb_fill_ctrl.sv
hdl/tlb_top.sv
testbench/tb_tlb_top.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the TLB testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_tlb_top -f tlb_top.f

output="$(./obj_dir/Vtb_tlb_top)"
echo "$output"

if echo "$output" | grep -qx "Test completed successfully"; then
    exit 0
else
    exit 1
fi

// File: testbench/tlb_tests.svh
// TLB directed tests

`ifndef TLB_TESTS_SVH
`define TLB_TESTS_SVH

// Set that is filled past capacity and the pages known to live in it
int                cap_set;
tlb_pkg::va_page_t cap_pages [$];

// ====================
// Reset and misses
// ====================

// Flags are low after reset, then every lookup into the empty TLB misses
task automatic test_reset_and_miss();
    tlb_pkg::va_page_t va;
    $display("Running reset and miss test");
    @(posedge clk);
    compare_flag(lookup_rdy, 1'b0, "lookup_rdy after reset");
    compare_flag(rsp_valid, 1'b0, "rsp_valid after reset");
    compare_flag(rsp_miss, 1'b0, "rsp_miss after reset");
    compare_flag(fill_ack, 1'b0, "fill_ack after reset");
    wait_ready();
    for (int i = 0; i < 16; i++)
    begin
        va = tlb_pkg::va_page_t'($urandom);
        issue_lookup(va);
    end
    stop_lookup();
    drain_results();
endtask

// ====================
// Single fill
// ====================

// The page misses before its fill and hits with the filled page afterwards
task automatic test_fill_then_hit();
    tlb_pkg::va_page_t va;
    tlb_pkg::pa_page_t pa;
    int                s;
    $display("Running fill and hit test");
    s  = empty_set();
    va = unused_page(s);
    pa = tlb_pkg::pa_page_t'($urandom);
    issue_lookup(va);
    stop_lookup();
    drain_results();
    fill_entry(va, pa);
    issue_lookup(va);
    stop_lookup();
    drain_results();
endtask

// ====================
// Back-to-back lookups
// ====================

// Filled and unfilled pages alternate, one lookup every cycle
task automatic test_back_to_back();
    tlb_pkg::va_page_t filled [$];
    tlb_pkg::va_page_t va;
    int                s;
    $display("Running back-to-back lookup test");
    for (int i = 0; i < 6; i++)
    begin
        s  = empty_set();
        va = unused_page(s);
        fill_entry(va, tlb_pkg::pa_page_t'($urandom));
        filled.push_back(va);
    end
    for (int i = 0; i < 24; i++)
    begin
        if (i % 2 == 0)
        begin
            va = filled[$urandom_range(filled.size() - 1, 0)];
        end
        else
        begin
            va = unused_page($urandom_range(num_sets - 1, 0));
        end
        issue_lookup(va);
    end
    stop_lookup();
    drain_results();
endtask

// ====================
// Set capacity
// ====================

// Four fills fill the set, a fifth one must replace exactly one of them
task automatic test_set_capacity();
    tlb_pkg::va_page_t first [$];
    tlb_pkg::va_page_t va;
    tlb_pkg::va_page_t fifth;
    int                hits;
    $display("Running set capacity test");
    cap_set = empty_set();
    for (int i = 0; i < num_ways; i++)
    begin
        va = unused_page(cap_set);
        fill_entry(va, tlb_pkg::pa_page_t'($urandom));
        first.push_back(va);
    end
    foreach (first[i])
    begin
        issue_lookup(first[i]);
    end
    stop_lookup();
    drain_results();

    fifth = unused_page(cap_set);
    fill_entry(fifth, tlb_pkg::pa_page_t'($urandom));

    // Which way the LFSR picked is not known here, so each old page may miss
    foreach (first[i])
    begin
        unsure[first[i]] = 1'b1;
    end
    outcome_hit.delete();
    outcome_va.delete();
    foreach (first[i])
    begin
        issue_lookup(first[i]);
    end
    issue_lookup(fifth);
    stop_lookup();
    drain_results();

    hits = 0;
    foreach (outcome_va[i])
    begin
        unsure.delete(outcome_va[i]);
        if (outcome_hit[i])
        begin
            hits++;
            cap_pages.push_back(outcome_va[i]);
        end
        else
        begin
            ref_map.delete(outcome_va[i]);
        end
    end
    if (outcome_va.size() != num_ways || hits != num_ways - 1)
    begin
        value_errors++;
        $display("[ERROR] %0t: %0d of %0d old pages in set %0d still hit, expected %0d",
                 $time, hits, outcome_va.size(), cap_set, num_ways - 1);
    end
    cap_pages.push_back(fifth);
endtask

// ====================
// Other sets
// ====================

// Fills elsewhere leave the full set alone
task automatic test_other_sets();
    tlb_pkg::va_page_t other [$];
    tlb_pkg::va_page_t va;
    int                s;
    $display("Running other sets test");
    for (int i = 0; i < 3; i++)
    begin
        s = empty_set();
        for (int j = 0; j < 2; j++)
        begin
            va = unused_page(s);
            fill_entry(va, tlb_pkg::pa_page_t'($urandom));
            other.push_back(va);
        end
    end
    foreach (cap_pages[i])
    begin
        issue_lookup(cap_pages[i]);
    end
    foreach (other[i])
    begin
        issue_lookup(other[i]);
    end
    stop_lookup();
    drain_results();
endtask

`endif

// File: testbench/tb_tlb_top.sv
// TLB testbench

`timescale 1ns/1ps

module tb_tlb_top;

    // ====================
    // Constants
    // ====================

    // Mirrors of the DUT default parameters
    localparam int num_sets       = 64;
    localparam int num_ways       = 4;
    localparam int idx_bits       = $clog2(num_sets);
    localparam int expect_latency = 5;

    localparam int clk_period   = 4;
    localparam int reset_cycles = 16;
    localparam int seed         = 94710;

    // Kinds of expected lookup result
    localparam logic [1:0] kind_miss   = 2'd0;
    localparam logic [1:0] kind_hit    = 2'd1;
    localparam logic [1:0] kind_either = 2'd2;

    // Rough cycle cost of one fill and of emptying the pipeline
    localparam int fill_cycles  = 12;
    localparam int drain_cycles = expect_latency + 4;
    localparam int wait_limit   = 20;

    // Init covers reset and the clearing sweep, then one budget per test
    localparam int init_cycles = reset_cycles + num_sets + 8;
    localparam int test_cycles = (17 + drain_cycles)
                               + (fill_cycles + 2 * drain_cycles + 2)
                               + (6 * fill_cycles + 24 + drain_cycles)
                               + (5 * fill_cycles + 9 + 2 * drain_cycles)
                               + (6 * fill_cycles + 9 + drain_cycles);
    localparam int watchdog_cycles = 2 * (init_cycles + test_cycles);

    typedef struct packed {
        logic [1:0]        kind;
        tlb_pkg::va_page_t va;
        tlb_pkg::pa_page_t pa;
    } expect_t;

    // ====================
    // DUT and clock
    // ====================

    logic              clk = 1'b0;
    logic              reset;
    logic              lookup_en;
    tlb_pkg::va_page_t lookup_va;
    logic              lookup_rdy;
    logic              rsp_valid;
    logic              rsp_miss;
    tlb_pkg::pa_page_t rsp_pa;
    tlb_pkg::va_page_t miss_va;
    logic              fill_req;
    tlb_pkg::va_page_t fill_va;
    tlb_pkg::pa_page_t fill_pa;
    logic              fill_ack;

    tlb_top u_tlb_top (
        .clk        (clk),
        .reset      (reset),
        .lookup_en  (lookup_en),
        .lookup_va  (lookup_va),
        .lookup_rdy (lookup_rdy),
        .rsp_valid  (rsp_valid),
        .rsp_miss   (rsp_miss),
        .rsp_pa     (rsp_pa),
        .miss_va    (miss_va),
        .fill_req   (fill_req),
        .fill_va    (fill_va),
        .fill_pa    (fill_pa),
        .fill_ack   (fill_ack)
    );

    always #(clk_period / 2) clk = ~clk;

    // ====================
    // Reference model and scoreboard
    // ====================

    // Pages the walker has filled and their translations
    tlb_pkg::pa_page_t ref_map [tlb_pkg::va_page_t];
    // Pages that may have been evicted by a replacement
    bit                unsure [tlb_pkg::va_page_t];
    int                fills_in_set [num_sets];

    expect_t           exp_q [$];
    longint            issue_q [$];
    logic              outcome_hit [$];
    tlb_pkg::va_page_t outcome_va [$];

    int     value_errors    = 0;
    int     protocol_errors = 0;
    int     issued_count    = 0;
    longint cycle_count     = 0;
    logic   ack_prev        = 1'b0;

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
    end

    // ====================
    // Compare tasks
    // ====================

    task automatic compare_pa(input tlb_pkg::pa_page_t got, input tlb_pkg::pa_page_t exp,
                              input tlb_pkg::va_page_t va);
        if (got !== exp)
        begin
            value_errors++;
            $display("[ERROR] %0t: page %h translated to %h, expected %h", $time, va, got, exp);
        end
    endtask

    task automatic compare_va(input tlb_pkg::va_page_t got, input tlb_pkg::va_page_t exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("[ERROR] %0t: miss_va is %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            value_errors++;
            $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Matches one result against the oldest outstanding lookup
    task automatic check_result();
        expect_t e;
        longint  issued;
        if (exp_q.size() == 0 || issue_q.size() == 0)
        begin
            value_errors++;
            $display("[ERROR] %0t: result seen with no lookup outstanding", $time);
            return;
        end
        e      = exp_q.pop_front();
        issued = issue_q.pop_front();
        if (cycle_count - issued != expect_latency)
        begin
            value_errors++;
            $display("[ERROR] %0t: result for page %h came %0d cycles after issue, expected %0d",
                     $time, e.va, cycle_count - issued, expect_latency);
        end
        if (e.kind == kind_either)
        begin
            outcome_hit.push_back(rsp_valid);
            outcome_va.push_back(e.va);
        end
        else
        begin
            compare_flag(rsp_valid, e.kind == kind_hit, $sformatf("hit flag of page %h", e.va));
        end
        if (rsp_valid)
        begin
            compare_pa(rsp_pa, e.pa, e.va);
        end
        else
        begin
            compare_va(miss_va, e.va);
        end
    endtask

    // Outputs are sampled on the falling edge, half a cycle after they change
    always @(negedge clk)
    begin
        // A lookup seen here is accepted on the next rising edge
        if (lookup_en && lookup_rdy)
        begin
            issue_q.push_back(cycle_count);
        end
        if (rsp_valid && rsp_miss)
        begin
            value_errors++;
            $display("[ERROR] %0t: rsp_valid and rsp_miss are both high", $time);
        end
        if (rsp_valid || rsp_miss)
        begin
            check_result();
        end
        if (fill_ack && !ack_prev && !fill_req)
        begin
            protocol_errors++;
            $display("The fill_ack signal rose at %0t while fill_req was low", $time);
        end
        if (!fill_ack && ack_prev && fill_req)
        begin
            protocol_errors++;
            $display("The fill_ack signal fell at %0t while fill_req was still high", $time);
        end
        ack_prev = fill_ack;
    end

    // ====================
    // Drivers
    // ====================

    task automatic issue_lookup(input tlb_pkg::va_page_t va);
        expect_t e;
        e.va   = va;
        e.pa   = '0;
        e.kind = kind_miss;
        if (ref_map.exists(va))
        begin
            e.pa   = ref_map[va];
            e.kind = unsure.exists(va) ? kind_either : kind_hit;
        end
        @(posedge clk);
        lookup_en <= 1'b1;
        lookup_va <= va;
        exp_q.push_back(e);
        issued_count++;
    endtask

    task automatic stop_lookup();
        @(posedge clk);
        lookup_en <= 1'b0;
    endtask

    // Waits until every outstanding lookup has returned
    task automatic drain_results();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < drain_cycles + 8)
        begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0)
        begin
            protocol_errors++;
            $display("Timed out at %0t with %0d lookup results never returned",
                     $time, exp_q.size());
            exp_q.delete();
            issue_q.delete();
        end
    endtask

    task automatic wait_ready();
        int waited;
        waited = 0;
        while (!lookup_rdy && waited < num_sets + 16)
        begin
            @(posedge clk);
            waited++;
        end
        if (!lookup_rdy)
        begin
            protocol_errors++;
            $display("The lookup_rdy signal never rose after reset");
        end
    endtask

    // Full four-phase fill, the model takes the entry once the ack is seen
    task automatic fill_entry(input tlb_pkg::va_page_t va, input tlb_pkg::pa_page_t pa);
        int waited;
        @(posedge clk);
        fill_req <= 1'b1;
        fill_va  <= va;
        fill_pa  <= pa;
        waited = 0;
        @(posedge clk);
        while (!fill_ack && waited < wait_limit)
        begin
            @(posedge clk);
            waited++;
        end
        if (!fill_ack)
        begin
            protocol_errors++;
            $display("Timed out at %0t waiting for fill_ack on page %h", $time, va);
        end
        else
        begin
            ref_map[va] = pa;
            fills_in_set[va[idx_bits-1:0]]++;
            // Holding the request a little longer catches an early ack drop
            repeat (2) @(posedge clk);
        end
        fill_req <= 1'b0;
        waited = 0;
        @(posedge clk);
        while (fill_ack && waited < wait_limit)
        begin
            @(posedge clk);
            waited++;
        end
        if (fill_ack)
        begin
            protocol_errors++;
            $display("The fill_ack signal stayed high after fill_req was released");
        end
    endtask

    // Random page in the given set that the model does not hold
    function automatic tlb_pkg::va_page_t unused_page(input int set_idx);
        tlb_pkg::va_page_t va;
        do
        begin
            va = tlb_pkg::va_page_t'($urandom);
            va[idx_bits-1:0] = set_idx[idx_bits-1:0];
        end
        while (ref_map.exists(va));
        return va;
    endfunction

    // Random set that has never been filled
    function automatic int empty_set();
        int s;
        do
        begin
            s = $urandom_range(num_sets - 1, 0);
        end
        while (fills_in_set[s] != 0);
        return s;
    endfunction

    `include "tlb_tests.svh"

    // ====================
    // Main sequence
    // ====================

    initial
    begin
        void'($urandom(seed));
        reset     = 1'b1;
        lookup_en = 1'b0;
        lookup_va = '0;
        fill_req  = 1'b0;
        fill_va   = '0;
        fill_pa   = '0;
        for (int s = 0; s < num_sets; s++)
        begin
            fills_in_set[s] = 0;
        end
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;

        test_reset_and_miss();
        test_fill_then_hit();
        test_back_to_back();
        test_set_capacity();
        test_other_sets();

        $display("Summary: %0d value errors, %0d protocol errors, %0d lookups issued",
                 value_errors, protocol_errors, issued_count);
        if (value_errors == 0 && protocol_errors == 0)
        begin
            $display("Test completed successfully");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

    // Hard stop in case a wait never returns
    initial
    begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles before the tests finished", watchdog_cycles);
        $display("Test failed");
        $finish;
    end

endmodule

// File: hdl/tlb_top.sv
// TLB top level

`timescale 1ns/1ps

module tlb_top #(
    parameter int num_sets = 64,
    parameter int num_ways = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              lookup_en,
    input  tlb_pkg::va_page_t lookup_va,
    output logic              lookup_rdy,
    output logic              rsp_valid,
    output logic              rsp_miss,
    output tlb_pkg::pa_page_t rsp_pa,
    output tlb_pkg::va_page_t miss_va,
    input  logic              fill_req,
    input  tlb_pkg::va_page_t fill_va,
    input  tlb_pkg::pa_page_t fill_pa,
    output logic              fill_ack
);

    localparam int idx_bits   = $clog2(num_sets);
    localparam int tag_bits   = tlb_pkg::va_page_bits - idx_bits;
    localparam int entry_bits = 1 + tag_bits + tlb_pkg::pa_page_bits;

    // Entries of all ways for one set
    typedef logic [num_ways-1:0][entry_bits-1:0] set_entries_t;

    // Fill write port, shared by all ways except for the enables
    logic [idx_bits-1:0]   fill_waddr;
    logic [entry_bits-1:0] fill_wdata;
    logic [num_ways-1:0]   fill_wen;

    // Read data from the ways, valid in stage 2
    set_entries_t        stage2_set;
    logic [num_ways-1:0] way_rdy;

    // Pipeline taps, tap 0 is stage 1
    logic                lookup_go;
    logic [tlb_pkg::lookup_latency-1:0] va_valid;
    tlb_pkg::va_page_t   va_tap [tlb_pkg::lookup_latency];
    logic [1:0]          set_valid;
    set_entries_t        set_tap [2];

    // ====================
    // Way stores
    // ====================

    // Every way clears on the same schedule, so way 0 speaks for all
    assign lookup_rdy = way_rdy[0];
    assign lookup_go  = lookup_en & lookup_rdy;

    for (genvar w = 0; w < num_ways; w++)
    begin : gen_way
        tlb_way_ram #(
            .num_sets   (num_sets),
            .entry_bits (entry_bits)
        ) u_way_ram (
            .clk   (clk),
            .reset (reset),
            .raddr (lookup_va[idx_bits-1:0]),
            .waddr (fill_waddr),
            .wen   (fill_wen[w]),
            .wdata (fill_wdata),
            .rdata (stage2_set[w]),
            .rdy   (way_rdy[w])
        );
    end

    // ====================
    // Lookup pipeline
    // ====================

    tlb_delay_line #(
        .payload_t (tlb_pkg::va_page_t),
        .depth     (tlb_pkg::lookup_latency)
    ) va_pipe (
        .clk       (clk),
        .reset     (reset),
        .din_valid (lookup_go),
        .din       (lookup_va),
        .tap_valid (va_valid),
        .tap       (va_tap)
    );

    // Set data enters in stage 2 and is needed again in stage 4
    tlb_delay_line #(
        .payload_t (set_entries_t),
        .depth     (2)
    ) set_pipe (
        .clk       (clk),
        .reset     (reset),
        .din_valid (va_valid[1]),
        .din       (stage2_set),
        .tap_valid (set_valid),
        .tap       (set_tap)
    );

    tlb_tag_compare #(
        .num_sets (num_sets),
        .num_ways (num_ways)
    ) u_tag_compare (
        .clk            (clk),
        .reset          (reset),
        .stage2_va      (va_tap[1]),
        .stage4_va      (va_tap[3]),
        .stage5_va      (va_tap[4]),
        .stage4_valid   (set_valid[1]),
        .stage2_entries (stage2_set),
        .stage4_entries (set_tap[1]),
        .rsp_valid      (rsp_valid),
        .rsp_miss       (rsp_miss),
        .rsp_pa         (rsp_pa),
        .miss_va        (miss_va)
    );

    // ====================
    // Fill path
    // ====================

    tlb_fill_ctrl #(
        .num_sets (num_sets),
        .num_ways (num_ways)
    ) u_fill_ctrl (
        .clk      (clk),
        .reset    (reset),
        .ready    (lookup_rdy),
        .fill_req (fill_req),
        .fill_va  (fill_va),
        .fill_pa  (fill_pa),
        .fill_ack (fill_ack),
        .waddr    (fill_waddr),
        .wdata    (fill_wdata),
        .wen      (fill_wen)
    );

endmodule

// File: hdl/tlb_fill_ctrl.sv
// TLB fill controller

`timescale 1ns/1ps

module tlb_fill_ctrl #(
    parameter int num_sets = 64,
    parameter int num_ways = 4
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        ready,
    input  logic                        fill_req,
    input  tlb_pkg::va_page_t           fill_va,
    input  tlb_pkg::pa_page_t           fill_pa,
    output logic                        fill_ack,
    output logic [$clog2(num_sets)-1:0] waddr,
    output logic [1+tlb_pkg::va_page_bits-$clog2(num_sets)+tlb_pkg::pa_page_bits-1:0]
                                        wdata,
    output logic [num_ways-1:0]         wen
);

    localparam int idx_bits = $clog2(num_sets);
    localparam int tag_bits = tlb_pkg::va_page_bits - idx_bits;
    localparam int way_bits = $clog2(num_ways);

    typedef enum logic [1:0] {
        st_idle,
        st_choose,
        st_write,
        st_release
    } fill_state_t;

    fill_state_t state;

    // Captured request, split into set index and tag
    logic [idx_bits-1:0] req_idx;
    logic [tag_bits-1:0] req_tag;
    tlb_pkg::pa_page_t   req_pa;

    // One valid bit per way per set, kept here so the victim choice
    // needs no read of the way stores
    logic [num_ways-1:0] set_valid [num_sets];

    // Free-running LFSR for replacement in a full set
    logic [15:0] lfsr;

    // Victim choice for the captured set
    logic [num_ways-1:0] cur_valid;
    logic [way_bits-1:0] free_way;
    logic [way_bits-1:0] victim;

    // ====================
    // Handshake FSM
    // ====================

    // Capture, choose and write take one cycle each, then the ack is held
    // until the walker drops its request
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= st_idle;
        end
        else
        begin
            case (state)
                st_idle:
                begin
                    if (fill_req && ready)
                    begin
                        state <= st_choose;
                    end
                end
                st_choose:  state <= st_write;
                st_write:   state <= st_release;
                st_release:
                begin
                    if (!fill_req)
                    begin
                        state <= st_idle;
                    end
                end
                default:    state <= st_idle;
            endcase
        end
    end

    // Request fields are stable while fill_req is high
    always_ff @(posedge clk)
    begin
        if (state == st_idle)
        begin
            req_idx <= fill_va[idx_bits-1:0];
            req_tag <= fill_va[tlb_pkg::va_page_bits-1:idx_bits];
            req_pa  <= fill_pa;
        end
        if (state == st_choose)
        begin
            victim <= (&cur_valid) ? lfsr[way_bits-1:0] : free_way;
        end
    end

    // ====================
    // Victim choice
    // ====================

    assign cur_valid = set_valid[req_idx];

    // Lowest invalid way, found by scanning down so the lowest wins
    always_comb
    begin
        free_way = '0;
        for (int w = num_ways - 1; w >= 0; w--)
        begin
            if (!cur_valid[w])
            begin
                free_way = way_bits'(w);
            end
        end
    end

    // Taps 16, 14, 13, 11 give a maximal length sequence
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            lfsr <= 16'hace1;
        end
        else
        begin
            lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        end
    end

    // Valid tracking is cleared together with the way stores
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int s = 0; s < num_sets; s++)
            begin
                set_valid[s] <= '0;
            end
        end
        else if (state == st_write)
        begin
            set_valid[req_idx][victim] <= 1'b1;
        end
    end

    // ====================
    // Way write and ack
    // ====================

    assign waddr = req_idx;
    assign wdata = {1'b1, req_tag, req_pa};

    always_comb
    begin
        for (int w = 0; w < num_ways; w++)
        begin
            wen[w] = (state == st_write) && (victim == way_bits'(w));
        end
    end

    // The entry is in the store by the edge on which the ack first shows
    assign fill_ack = (state == st_release);

endmodule

// File: hdl/tlb_tag_compare.sv
// TLB tag compare and result

`timescale 1ns/1ps

module tlb_tag_compare #(
    parameter int num_sets = 64,
    parameter int num_ways = 4
) (
    input  logic                clk,
    input  logic                reset,
    input  tlb_pkg::va_page_t   stage2_va,
    input  tlb_pkg::va_page_t   stage4_va,
    input  tlb_pkg::va_page_t   stage5_va,
    input  logic                stage4_valid,
    input  logic [num_ways-1:0][1+tlb_pkg::va_page_bits-$clog2(num_sets)+tlb_pkg::pa_page_bits-1:0]
                                stage2_entries,
    input  logic [num_ways-1:0][1+tlb_pkg::va_page_bits-$clog2(num_sets)+tlb_pkg::pa_page_bits-1:0]
                                stage4_entries,
    output logic                rsp_valid,
    output logic                rsp_miss,
    output tlb_pkg::pa_page_t   rsp_pa,
    output tlb_pkg::va_page_t   miss_va
);

    localparam int idx_bits   = $clog2(num_sets);
    localparam int tag_bits   = tlb_pkg::va_page_bits - idx_bits;
    localparam int entry_bits = 1 + tag_bits + tlb_pkg::pa_page_bits;
    localparam int way_bits   = $clog2(num_ways);

    // Per-way partial compare registered at the end of stage 2
    logic [tag_bits-1:0] stg3_xor [num_ways];
    logic [num_ways-1:0] stg3_valid;

    // Per-way match registered at the end of stage 3
    logic [num_ways-1:0] stg4_match;

    // Stage 4 combinational hit detection
    logic                stg4_hit;
    logic [way_bits-1:0] stg4_way;

    // ====================
    // Stage 2
    // ====================

    // A full tag compare is too deep for one cycle, so only the XOR is
    // taken here and the reduction waits for stage 3
    always_ff @(posedge clk)
    begin
        for (int w = 0; w < num_ways; w++)
        begin
            stg3_xor[w]   <= stage2_entries[w][entry_bits-2 -: tag_bits] ^
                             stage2_va[tlb_pkg::va_page_bits-1:idx_bits];
            stg3_valid[w] <= stage2_entries[w][entry_bits-1];
        end
    end

    // ====================
    // Stage 3
    // ====================

    // A way matches when every XOR bit is zero and its entry is valid
    always_ff @(posedge clk)
    begin
        for (int w = 0; w < num_ways; w++)
        begin
            stg4_match[w] <= stg3_valid[w] & ~(|stg3_xor[w]);
        end
    end

    // ====================
    // Stage 4
    // ====================

    // The walker never fills a page twice, so at most one way matches
    // The lowest matching way is taken all the same
    always_comb
    begin
        stg4_hit = |stg4_match;
        stg4_way = '0;
        for (int w = num_ways - 1; w >= 0; w--)
        begin
            if (stg4_match[w])
            begin
                stg4_way = way_bits'(w);
            end
        end
    end

    // Hit or miss flag and the chosen page enter stage 5 on the same edge
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rsp_valid <= 1'b0;
            rsp_miss  <= 1'b0;
        end
        else
        begin
            rsp_valid <= stage4_valid & stg4_hit;
            rsp_miss  <= stage4_valid & ~stg4_hit;
        end
        rsp_pa <= stage4_entries[stg4_way][tlb_pkg::pa_page_bits-1:0];
    end

    // The miss page shown with the result is the stage 5 copy of the lookup
    assign miss_va = stage5_va;

endmodule

// File: hdl/tlb_delay_line.sv
// TLB pipeline delay line

`timescale 1ns/1ps

module tlb_delay_line #(
    parameter type payload_t = logic,
    parameter int  depth     = 2
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             din_valid,
    input  payload_t         din,
    output logic [depth-1:0] tap_valid,
    output payload_t         tap [depth]
);

    // Valid bits are control state and start cleared
    // tap_valid[0] is one cycle behind din_valid
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            tap_valid <= '0;
        end
        else
        begin
            tap_valid[0] <= din_valid;
            for (int s = 1; s < depth; s++)
            begin
                tap_valid[s] <= tap_valid[s-1];
            end
        end
    end

    // Payload moves every cycle whether or not its stage holds a lookup
    always_ff @(posedge clk)
    begin
        tap[0] <= din;
        for (int s = 1; s < depth; s++)
        begin
            tap[s] <= tap[s-1];
        end
    end

endmodule

// File: hdl/tlb_way_ram.sv
// TLB way tag store

`timescale 1ns/1ps

module tlb_way_ram #(
    parameter int num_sets   = 64,
    parameter int entry_bits = 33
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [$clog2(num_sets)-1:0] raddr,
    input  logic [$clog2(num_sets)-1:0] waddr,
    input  logic                        wen,
    input  logic [entry_bits-1:0]       wdata,
    output logic [entry_bits-1:0]       rdata,
    output logic                        rdy
);

    localparam int idx_bits = $clog2(num_sets);

    // One entry per set, valid bit in the top position
    logic [entry_bits-1:0] mem [num_sets];

    // Set being cleared by the post-reset sweep
    logic [idx_bits-1:0] sweep_idx;

    // Read address register, the first of the two read cycles
    logic [idx_bits-1:0] raddr_q;

    // ====================
    // Clearing sweep
    // ====================

    // After reset the sweep walks every set once and then raises rdy
    // Nothing may be looked up or filled until rdy is high
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            sweep_idx <= '0;
            rdy       <= 1'b0;
        end
        else if (!rdy)
        begin
            sweep_idx <= sweep_idx + 1'b1;
            // The last set is written on this edge
            if (sweep_idx == idx_bits'(num_sets - 1))
            begin
                rdy <= 1'b1;
            end
        end
    end

    // ====================
    // Storage and read
    // ====================

    // While the sweep runs it owns the write port and writes zero entries
    // Afterwards only the fill controller writes
    always_ff @(posedge clk)
    begin
        if (!rdy)
        begin
            mem[sweep_idx] <= '0;
        end
        else if (wen)
        begin
            mem[waddr] <= wdata;
        end

        // Address and output registers give a two-cycle read, like a block RAM
        // A write on the same edge as the address capture is seen by the read
        raddr_q <= raddr;
        rdata   <= mem[raddr_q];
    end

endmodule

// File: hdl/tlb_pkg.sv
// TLB shared definitions

package tlb_pkg;

    // ====================
    // Page index widths
    // ====================

    // All indices are page indices of one fixed page size
    // The low bits of a virtual page select the set and the rest form the tag
    localparam int va_page_bits = 20;

    // Physical page index returned on a hit
    localparam int pa_page_bits = 20;

    // ====================
    // Page index types
    // ====================

    // Virtual page index as seen on the lookup and fill ports
    typedef logic [va_page_bits-1:0] va_page_t;

    // Physical page index as stored in a way entry
    typedef logic [pa_page_bits-1:0] pa_page_t;

    // ====================
    // Pipeline timing
    // ====================

    // Cycles from an accepted lookup to its hit or miss result
    // Stage 1 registers the set address in the ways
    // Stage 2 sees the set data and starts the tag XOR
    // Stage 3 reduces the XOR to one match bit per way
    // Stage 4 picks the hitting way, and the result is registered into stage 5
    localparam int lookup_latency = 5;

endpackage
